// ==== files.f ====
+incdir+test
hw/core_trace_pkg.sv
hw/lsu_trace_pkg.sv
hw/operand_capture.sv
hw/mem_capture.sv
hw/retire_record.sv
hw/trace_top.sv
test/tb_trace_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the trace unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_trace_top -o sim_trace_top

./obj_dir/sim_trace_top

// ==== test/tb_trace_cases.svh ====
// Instruction cases for the trace testbench
// Stimulus per row followed by the expected trace record
`ifndef TB_TRACE_CASES_SVH
`define TB_TRACE_CASES_SVH

localparam int NumCases = 8;

case_t cases [NumCases];

// Row layout
//   rs1_addr, rs1_rdata, rs2_addr, rs2_rdata, rd_addr, rd_wdata, rd_we,
//   insn, insn_c, compressed, pc, data_type, data_we, pulses, addr0, addr1,
//   rdata, wdata, errs {load,store,cap,illegal}, irq,
//   exp_rd_addr, exp_rd_wdata, exp_insn, exp_rmask, exp_wmask, exp_trap
task automatic fill_cases();
  // Word load into x3
  cases[0] = '{5'd1, 32'h1111_0001, 5'd2, 32'h2222_0002, 5'd3, 32'h3333_0003, 1'b1,
               32'h0000_a183, 16'h0000, 1'b0, 32'h0000_0100, 2'd0, 1'b0, 2'd1,
               32'h0000_2000, 32'h0000_0000, 64'h0000_0000_dead_beef, 64'h0000_0000_0000_0000,
               4'b0000, 1'b0, 5'd3, 32'h3333_0003, 32'h0000_a183, 8'h0f, 8'h00, 1'b0};
  // Half store, no register write
  cases[1] = '{5'd4, 32'h4444_0004, 5'd5, 32'h5555_0005, 5'd7, 32'h7777_0007, 1'b0,
               32'h0051_1023, 16'h0000, 1'b0, 32'h0000_0104, 2'd1, 1'b1, 2'd1,
               32'h0000_2010, 32'h0000_0000, 64'h0000_0000_0000_1234, 64'h0000_0000_0000_abcd,
               4'b0000, 1'b0, 5'd0, 32'h0000_0000, 32'h0051_1023, 8'h03, 8'h03, 1'b0};
  // Byte load into x0 reports zero data
  cases[2] = '{5'd6, 32'h6666_0006, 5'd8, 32'h8888_0008, 5'd0, 32'hcafe_f00d, 1'b1,
               32'h0003_0003, 16'h0000, 1'b0, 32'h0000_0108, 2'd2, 1'b0, 2'd1,
               32'h0000_2021, 32'h0000_0000, 64'h0000_0000_0000_005a, 64'h0000_0000_0000_0000,
               4'b0000, 1'b0, 5'd0, 32'h0000_0000, 32'h0003_0003, 8'h01, 8'h00, 1'b0};
  // Capability store split over two LSU pulses
  cases[3] = '{5'd9, 32'h9999_0009, 5'd10, 32'haaaa_000a, 5'd0, 32'h0000_0000, 1'b0,
               32'h00a4_b023, 16'h0000, 1'b0, 32'h0000_010c, 2'd3, 1'b1, 2'd2,
               32'h0000_3000, 32'h0000_3004, 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
               4'b0000, 1'b0, 5'd0, 32'h0000_0000, 32'h00a4_b023, 8'hff, 8'hff, 1'b0};
  // Load with bus error
  cases[4] = '{5'd11, 32'hbbbb_000b, 5'd12, 32'hcccc_000c, 5'd13, 32'hdddd_000d, 1'b1,
               32'h000a_a683, 16'h0000, 1'b0, 32'h0000_0110, 2'd0, 1'b0, 2'd1,
               32'h0000_4000, 32'h0000_0000, 64'h0000_0000_0bad_0bad, 64'h0000_0000_0000_0000,
               4'b1000, 1'b0, 5'd13, 32'hdddd_000d, 32'h000a_a683, 8'h0f, 8'h00, 1'b1};
  // Store error together with an interrupt
  cases[5] = '{5'd14, 32'heeee_000e, 5'd15, 32'hffff_000f, 5'd0, 32'h0000_0000, 1'b0,
               32'h00f7_2023, 16'h0000, 1'b0, 32'h0000_0114, 2'd0, 1'b1, 2'd1,
               32'h0000_4010, 32'h0000_0000, 64'h0000_0000_0000_0000, 64'h0000_0000_1357_9bdf,
               4'b0100, 1'b1, 5'd0, 32'h0000_0000, 32'h00f7_2023, 8'h0f, 8'h0f, 1'b1};
  // Compressed instruction with capability exception
  cases[6] = '{5'd16, 32'h1010_0010, 5'd17, 32'h1111_0011, 5'd10, 32'h0000_0005, 1'b1,
               32'h0050_0513, 16'h4515, 1'b1, 32'h0000_0118, 2'd2, 1'b0, 2'd1,
               32'h0000_5001, 32'h0000_0000, 64'h0000_0000_0000_0077, 64'h0000_0000_0000_0000,
               4'b0010, 1'b0, 5'd10, 32'h0000_0005, 32'h0000_4515, 8'h01, 8'h00, 1'b1};
  // Illegal instruction
  cases[7] = '{5'd18, 32'h1212_0012, 5'd19, 32'h1313_0013, 5'd20, 32'h1414_0014, 1'b1,
               32'hffff_ffff, 16'h0000, 1'b0, 32'h0000_011c, 2'd1, 1'b0, 2'd1,
               32'h0000_6002, 32'h0000_0000, 64'h0000_0000_0000_8001, 64'h0000_0000_0000_0000,
               4'b0001, 1'b1, 5'd20, 32'h1414_0014, 32'hffff_ffff, 8'h03, 8'h00, 1'b1};
endtask

`endif

// ==== test/tb_trace_top.sv ====
// Testbench for the retirement trace unit
// Table driven instruction cases, record checks and a watchdog

module tb_trace_top;

  typedef struct packed {
    logic [4:0]  rs1_addr;
    logic [31:0] rs1_rdata;
    logic [4:0]  rs2_addr;
    logic [31:0] rs2_rdata;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        rd_we;
    logic [31:0] insn;
    logic [15:0] insn_c;
    logic        compressed;
    logic [31:0] pc;
    logic [1:0]  data_type;
    logic        data_we;
    logic [1:0]  pulses;
    logic [31:0] addr0;
    logic [31:0] addr1;
    logic [63:0] rdata;
    logic [63:0] wdata;
    logic [3:0]  errs;
    logic        irq;
    logic [4:0]  exp_rd_addr;
    logic [31:0] exp_rd_wdata;
    logic [31:0] exp_insn;
    logic [7:0]  exp_rmask;
    logic [7:0]  exp_wmask;
    logic        exp_trap;
  } case_t;

  `include "tb_trace_cases.svh"

  logic        clk;
  logic        rst_ni;
  logic        instr_new_i;
  logic        instr_ret_i;
  logic [4:0]  rs1_addr_i;
  logic [4:0]  rs2_addr_i;
  logic [31:0] rs1_rdata_i;
  logic [31:0] rs2_rdata_i;
  logic [4:0]  rd_addr_i;
  logic [31:0] rd_wdata_i;
  logic        rd_we_i;
  logic [31:0] insn_rdata_i;
  logic [15:0] insn_c_rdata_i;
  logic        insn_compressed_i;
  logic [31:0] pc_i;
  logic [1:0]  data_type_i;
  logic        data_we_i;
  logic        lsu_data_valid_i;
  logic        lsu_addr_incr_i;
  logic [31:0] data_addr_i;
  logic [63:0] data_rdata_i;
  logic [63:0] data_wdata_i;
  logic        load_err_i;
  logic        store_err_i;
  logic        cap_exc_i;
  logic        illegal_insn_i;
  logic        irq_ack_i;

  logic        rvfi_valid_o;
  logic [63:0] rvfi_order_o;
  logic [31:0] rvfi_insn_o;
  logic [31:0] rvfi_insn_uncompressed_o;
  logic        rvfi_trap_o;
  logic        rvfi_intr_o;
  logic [4:0]  rvfi_rs1_addr_o;
  logic [4:0]  rvfi_rs2_addr_o;
  logic [31:0] rvfi_rs1_rdata_o;
  logic [31:0] rvfi_rs2_rdata_o;
  logic [4:0]  rvfi_rd_addr_o;
  logic [31:0] rvfi_rd_wdata_o;
  logic [31:0] rvfi_pc_rdata_o;
  logic [31:0] rvfi_mem_addr_o;
  logic [63:0] rvfi_mem_rdata_o;
  logic [63:0] rvfi_mem_wdata_o;
  logic [7:0]  rvfi_mem_rmask_o;
  logic [7:0]  rvfi_mem_wmask_o;

  trace_top #(
    .OrderWidth (64)
  ) uut (
    .clk (clk), .rst_ni (rst_ni),
    .instr_new_i (instr_new_i), .instr_ret_i (instr_ret_i),
    .rs1_addr_i (rs1_addr_i), .rs2_addr_i (rs2_addr_i),
    .rs1_rdata_i (rs1_rdata_i), .rs2_rdata_i (rs2_rdata_i),
    .rd_addr_i (rd_addr_i), .rd_wdata_i (rd_wdata_i), .rd_we_i (rd_we_i),
    .insn_rdata_i (insn_rdata_i), .insn_c_rdata_i (insn_c_rdata_i),
    .insn_compressed_i (insn_compressed_i), .pc_i (pc_i),
    .data_type_i (data_type_i), .data_we_i (data_we_i),
    .lsu_data_valid_i (lsu_data_valid_i), .lsu_addr_incr_i (lsu_addr_incr_i),
    .data_addr_i (data_addr_i), .data_rdata_i (data_rdata_i), .data_wdata_i (data_wdata_i),
    .load_err_i (load_err_i), .store_err_i (store_err_i), .cap_exc_i (cap_exc_i),
    .illegal_insn_i (illegal_insn_i), .irq_ack_i (irq_ack_i),
    .rvfi_valid_o (rvfi_valid_o), .rvfi_order_o (rvfi_order_o),
    .rvfi_insn_o (rvfi_insn_o), .rvfi_insn_uncompressed_o (rvfi_insn_uncompressed_o),
    .rvfi_trap_o (rvfi_trap_o), .rvfi_intr_o (rvfi_intr_o),
    .rvfi_rs1_addr_o (rvfi_rs1_addr_o), .rvfi_rs2_addr_o (rvfi_rs2_addr_o),
    .rvfi_rs1_rdata_o (rvfi_rs1_rdata_o), .rvfi_rs2_rdata_o (rvfi_rs2_rdata_o),
    .rvfi_rd_addr_o (rvfi_rd_addr_o), .rvfi_rd_wdata_o (rvfi_rd_wdata_o),
    .rvfi_pc_rdata_o (rvfi_pc_rdata_o), .rvfi_mem_addr_o (rvfi_mem_addr_o),
    .rvfi_mem_rdata_o (rvfi_mem_rdata_o), .rvfi_mem_wdata_o (rvfi_mem_wdata_o),
    .rvfi_mem_rmask_o (rvfi_mem_rmask_o), .rvfi_mem_wmask_o (rvfi_mem_wmask_o)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_record(input case_t c, input int idx);
    if (rvfi_valid_o !== 1'b1) begin
      $display("Trace record of case %0d did not appear after retire", idx);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
    check_value("rvfi_order_o", rvfi_order_o, 64'(idx));
    check_value("rvfi_insn_o", 64'(rvfi_insn_o), 64'(c.exp_insn));
    check_value("rvfi_insn_uncompressed_o", 64'(rvfi_insn_uncompressed_o), 64'(c.insn));
    check_value("rvfi_trap_o", 64'(rvfi_trap_o), 64'(c.exp_trap));
    check_value("rvfi_intr_o", 64'(rvfi_intr_o), 64'(c.irq));
    check_value("rvfi_rs1_addr_o", 64'(rvfi_rs1_addr_o), 64'(c.rs1_addr));
    check_value("rvfi_rs2_addr_o", 64'(rvfi_rs2_addr_o), 64'(c.rs2_addr));
    check_value("rvfi_rs1_rdata_o", 64'(rvfi_rs1_rdata_o), 64'(c.rs1_rdata));
    check_value("rvfi_rs2_rdata_o", 64'(rvfi_rs2_rdata_o), 64'(c.rs2_rdata));
    check_value("rvfi_rd_addr_o", 64'(rvfi_rd_addr_o), 64'(c.exp_rd_addr));
    check_value("rvfi_rd_wdata_o", 64'(rvfi_rd_wdata_o), 64'(c.exp_rd_wdata));
    check_value("rvfi_pc_rdata_o", 64'(rvfi_pc_rdata_o), 64'(c.pc));
    // Split accesses report the first address
    check_value("rvfi_mem_addr_o", 64'(rvfi_mem_addr_o), 64'(c.addr0));
    check_value("rvfi_mem_rdata_o", rvfi_mem_rdata_o, c.rdata);
    check_value("rvfi_mem_wdata_o", rvfi_mem_wdata_o, c.wdata);
    check_value("rvfi_mem_rmask_o", 64'(rvfi_mem_rmask_o), 64'(c.exp_rmask));
    check_value("rvfi_mem_wmask_o", 64'(rvfi_mem_wmask_o), 64'(c.exp_wmask));
  endtask

  //////////////////////////////
  // Driver
  //////////////////////////////

  task automatic apply_case(input case_t c);
    int p;
    @(posedge clk);
    #2;
    instr_new_i       = 1'b1;
    rs1_addr_i        = c.rs1_addr;
    rs2_addr_i        = c.rs2_addr;
    rs1_rdata_i       = c.rs1_rdata;
    rs2_rdata_i       = c.rs2_rdata;
    rd_addr_i         = c.rd_addr;
    rd_wdata_i        = c.rd_wdata;
    rd_we_i           = c.rd_we;
    insn_rdata_i      = c.insn;
    insn_c_rdata_i    = c.insn_c;
    insn_compressed_i = c.compressed;
    pc_i              = c.pc;
    data_type_i       = c.data_type;
    data_we_i         = c.data_we;
    @(posedge clk);
    #2;
    instr_new_i = 1'b0;
    // Sources move on after decode
    rs1_addr_i  = ~c.rs1_addr;
    rs2_addr_i  = ~c.rs2_addr;
    rs1_rdata_i = ~c.rs1_rdata;
    rs2_rdata_i = ~c.rs2_rdata;
    for (p = 0; p < int'(c.pulses); p++) begin
      lsu_data_valid_i = 1'b1;
      lsu_addr_incr_i  = (p == 1);
      data_addr_i      = (p == 1) ? c.addr1 : c.addr0;
      // Only the last pulse carries the data the record must show
      data_rdata_i     = (p == int'(c.pulses) - 1) ? c.rdata : ~c.rdata;
      data_wdata_i     = (p == int'(c.pulses) - 1) ? c.wdata : ~c.wdata;
      @(posedge clk);
      #2;
    end
    lsu_data_valid_i = 1'b0;
    lsu_addr_incr_i  = 1'b0;
    instr_ret_i      = 1'b1;
    {load_err_i, store_err_i, cap_exc_i, illegal_insn_i} = c.errs;
    irq_ack_i        = c.irq;
    @(posedge clk);
    #2;
    instr_ret_i = 1'b0;
    {load_err_i, store_err_i, cap_exc_i, illegal_insn_i} = 4'b0000;
    irq_ack_i   = 1'b0;
  endtask

  initial begin
    #((NumCases * 10 + 50) * 20);
    $display("Watchdog expired before all cases finished");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  initial begin
    clk = 1'b0;
    rst_ni = 1'b0;
    instr_new_i = 1'b0;
    instr_ret_i = 1'b0;
    rs1_addr_i = '0;
    rs2_addr_i = '0;
    rs1_rdata_i = '0;
    rs2_rdata_i = '0;
    rd_addr_i = '0;
    rd_wdata_i = '0;
    rd_we_i = 1'b0;
    insn_rdata_i = '0;
    insn_c_rdata_i = '0;
    insn_compressed_i = 1'b0;
    pc_i = '0;
    data_type_i = '0;
    data_we_i = 1'b0;
    lsu_data_valid_i = 1'b0;
    lsu_addr_incr_i = 1'b0;
    data_addr_i = '0;
    data_rdata_i = '0;
    data_wdata_i = '0;
    load_err_i = 1'b0;
    store_err_i = 1'b0;
    cap_exc_i = 1'b0;
    illegal_insn_i = 1'b0;
    irq_ack_i = 1'b0;
    fill_cases();
    repeat (3) @(posedge clk);
    #2;
    rst_ni = 1'b1;
    // Quiet outputs before the first instruction
    check_value("rvfi_valid_o", 64'(rvfi_valid_o), 64'h0);
    check_value("rvfi_trap_o", 64'(rvfi_trap_o), 64'h0);
    check_value("rvfi_order_o", rvfi_order_o, 64'h0);
    for (int i = 0; i < NumCases; i++) begin
      apply_case(cases[i]);
      check_record(cases[i], i);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== hw/trace_top.sv ====
// Top level of the retirement trace unit
// Connects operand capture, memory capture and the retire record

module trace_top #(
  parameter int unsigned OrderWidth = core_trace_pkg::OrderWidthDefault
) (
  input  logic                      clk,
  input  logic                      rst_ni,

  // Decode and retire strobes
  input  logic                      instr_new_i,
  input  logic                      instr_ret_i,

  // Register file
  input  core_trace_pkg::reg_addr_t rs1_addr_i,
  input  core_trace_pkg::reg_addr_t rs2_addr_i,
  input  core_trace_pkg::xlen_t     rs1_rdata_i,
  input  core_trace_pkg::xlen_t     rs2_rdata_i,
  input  core_trace_pkg::reg_addr_t rd_addr_i,
  input  core_trace_pkg::xlen_t     rd_wdata_i,
  input  logic                      rd_we_i,

  // Instruction in decode
  input  core_trace_pkg::insn_t     insn_rdata_i,
  input  core_trace_pkg::insn_c_t   insn_c_rdata_i,
  input  logic                      insn_compressed_i,
  input  core_trace_pkg::xlen_t     pc_i,

  // Load/store unit
  input  lsu_trace_pkg::data_type_t data_type_i,
  input  logic                      data_we_i,
  input  logic                      lsu_data_valid_i,
  input  logic                      lsu_addr_incr_i,
  input  core_trace_pkg::xlen_t     data_addr_i,
  input  lsu_trace_pkg::mem_data_t  data_rdata_i,
  input  lsu_trace_pkg::mem_data_t  data_wdata_i,

  // Trap and interrupt sources, sampled at retire
  input  logic                      load_err_i,
  input  logic                      store_err_i,
  input  logic                      cap_exc_i,
  input  logic                      illegal_insn_i,
  input  logic                      irq_ack_i,

  // Trace record
  output logic                      rvfi_valid_o,
  output logic [OrderWidth-1:0]     rvfi_order_o,
  output core_trace_pkg::insn_t     rvfi_insn_o,
  output core_trace_pkg::insn_t     rvfi_insn_uncompressed_o,
  output logic                      rvfi_trap_o,
  output logic                      rvfi_intr_o,
  output core_trace_pkg::reg_addr_t rvfi_rs1_addr_o,
  output core_trace_pkg::reg_addr_t rvfi_rs2_addr_o,
  output core_trace_pkg::xlen_t     rvfi_rs1_rdata_o,
  output core_trace_pkg::xlen_t     rvfi_rs2_rdata_o,
  output core_trace_pkg::reg_addr_t rvfi_rd_addr_o,
  output core_trace_pkg::xlen_t     rvfi_rd_wdata_o,
  output core_trace_pkg::xlen_t     rvfi_pc_rdata_o,
  output core_trace_pkg::xlen_t     rvfi_mem_addr_o,
  output lsu_trace_pkg::mem_data_t  rvfi_mem_rdata_o,
  output lsu_trace_pkg::mem_data_t  rvfi_mem_wdata_o,
  output lsu_trace_pkg::mem_mask_t  rvfi_mem_rmask_o,
  output lsu_trace_pkg::mem_mask_t  rvfi_mem_wmask_o
);

  import core_trace_pkg::*;
  import lsu_trace_pkg::*;

  logic      insn_open;

  // Held operand view
  reg_addr_t op_rs1_addr;
  reg_addr_t op_rs2_addr;
  reg_addr_t op_rd_addr;
  xlen_t     op_rs1_rdata;
  xlen_t     op_rs2_rdata;
  xlen_t     op_rd_wdata;

  // Held memory view
  xlen_t     mem_addr;
  mem_data_t mem_rdata;
  mem_data_t mem_wdata;
  mem_mask_t mem_mask;

  //////////////////////////////
  // Operand capture
  //////////////////////////////

  operand_capture u_operand_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_new_i (instr_new_i),
    .instr_ret_i (instr_ret_i),
    .rs1_addr_i  (rs1_addr_i),
    .rs2_addr_i  (rs2_addr_i),
    .rs1_rdata_i (rs1_rdata_i),
    .rs2_rdata_i (rs2_rdata_i),
    .rd_addr_i   (rd_addr_i),
    .rd_wdata_i  (rd_wdata_i),
    .rd_we_i     (rd_we_i),
    .insn_open_o (insn_open),
    .rs1_addr_o  (op_rs1_addr),
    .rs2_addr_o  (op_rs2_addr),
    .rd_addr_o   (op_rd_addr),
    .rs1_rdata_o (op_rs1_rdata),
    .rs2_rdata_o (op_rs2_rdata),
    .rd_wdata_o  (op_rd_wdata)
  );

  //////////////////////////////
  // Memory capture
  //////////////////////////////

  mem_capture u_mem_capture (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .insn_open_i      (insn_open),
    .lsu_data_valid_i (lsu_data_valid_i),
    .lsu_addr_incr_i  (lsu_addr_incr_i),
    .data_addr_i      (data_addr_i),
    .data_rdata_i     (data_rdata_i),
    .data_wdata_i     (data_wdata_i),
    .data_type_i      (data_type_i),
    .mem_addr_o       (mem_addr),
    .mem_rdata_o      (mem_rdata),
    .mem_wdata_o      (mem_wdata),
    .mem_mask_o       (mem_mask)
  );

  //////////////////////////////
  // Retire record
  //////////////////////////////

  retire_record #(
    .OrderWidth (OrderWidth)
  ) u_retire_record (
    .clk                      (clk),
    .rst_ni                   (rst_ni),
    .instr_ret_i              (instr_ret_i),
    .irq_ack_i                (irq_ack_i),
    .load_err_i               (load_err_i),
    .store_err_i              (store_err_i),
    .cap_exc_i                (cap_exc_i),
    .illegal_insn_i           (illegal_insn_i),
    .insn_compressed_i        (insn_compressed_i),
    .data_we_i                (data_we_i),
    .insn_rdata_i             (insn_rdata_i),
    .insn_c_rdata_i           (insn_c_rdata_i),
    .pc_i                     (pc_i),
    .rs1_addr_i               (op_rs1_addr),
    .rs2_addr_i               (op_rs2_addr),
    .rd_addr_i                (op_rd_addr),
    .rs1_rdata_i              (op_rs1_rdata),
    .rs2_rdata_i              (op_rs2_rdata),
    .rd_wdata_i               (op_rd_wdata),
    .mem_addr_i               (mem_addr),
    .mem_rdata_i              (mem_rdata),
    .mem_wdata_i              (mem_wdata),
    .mem_mask_i               (mem_mask),
    .rvfi_valid_o             (rvfi_valid_o),
    .rvfi_order_o             (rvfi_order_o),
    .rvfi_insn_o              (rvfi_insn_o),
    .rvfi_insn_uncompressed_o (rvfi_insn_uncompressed_o),
    .rvfi_trap_o              (rvfi_trap_o),
    .rvfi_intr_o              (rvfi_intr_o),
    .rvfi_rs1_addr_o          (rvfi_rs1_addr_o),
    .rvfi_rs2_addr_o          (rvfi_rs2_addr_o),
    .rvfi_rs1_rdata_o         (rvfi_rs1_rdata_o),
    .rvfi_rs2_rdata_o         (rvfi_rs2_rdata_o),
    .rvfi_rd_addr_o           (rvfi_rd_addr_o),
    .rvfi_rd_wdata_o          (rvfi_rd_wdata_o),
    .rvfi_pc_rdata_o          (rvfi_pc_rdata_o),
    .rvfi_mem_addr_o          (rvfi_mem_addr_o),
    .rvfi_mem_rdata_o         (rvfi_mem_rdata_o),
    .rvfi_mem_wdata_o         (rvfi_mem_wdata_o),
    .rvfi_mem_rmask_o         (rvfi_mem_rmask_o),
    .rvfi_mem_wmask_o         (rvfi_mem_wmask_o)
  );

endmodule

// ==== hw/retire_record.sv ====
// Retire record for the retirement trace
// Registers one trace record per retired instruction and counts retirements

module retire_record #(
  parameter int unsigned OrderWidth = core_trace_pkg::OrderWidthDefault
) (
  input  logic                      clk,
  input  logic                      rst_ni,

  // Retire cycle control
  input  logic                      instr_ret_i,
  input  logic                      irq_ack_i,
  input  logic                      load_err_i,
  input  logic                      store_err_i,
  input  logic                      cap_exc_i,
  input  logic                      illegal_insn_i,
  input  logic                      insn_compressed_i,
  input  logic                      data_we_i,

  input  core_trace_pkg::insn_t     insn_rdata_i,
  input  core_trace_pkg::insn_c_t   insn_c_rdata_i,
  input  core_trace_pkg::xlen_t     pc_i,

  // From operand capture
  input  core_trace_pkg::reg_addr_t rs1_addr_i,
  input  core_trace_pkg::reg_addr_t rs2_addr_i,
  input  core_trace_pkg::reg_addr_t rd_addr_i,
  input  core_trace_pkg::xlen_t     rs1_rdata_i,
  input  core_trace_pkg::xlen_t     rs2_rdata_i,
  input  core_trace_pkg::xlen_t     rd_wdata_i,

  // From memory capture
  input  core_trace_pkg::xlen_t     mem_addr_i,
  input  lsu_trace_pkg::mem_data_t  mem_rdata_i,
  input  lsu_trace_pkg::mem_data_t  mem_wdata_i,
  input  lsu_trace_pkg::mem_mask_t  mem_mask_i,

  // Trace record
  output logic                      rvfi_valid_o,
  output logic [OrderWidth-1:0]     rvfi_order_o,
  output core_trace_pkg::insn_t     rvfi_insn_o,
  output core_trace_pkg::insn_t     rvfi_insn_uncompressed_o,
  output logic                      rvfi_trap_o,
  output logic                      rvfi_intr_o,
  output core_trace_pkg::reg_addr_t rvfi_rs1_addr_o,
  output core_trace_pkg::reg_addr_t rvfi_rs2_addr_o,
  output core_trace_pkg::xlen_t     rvfi_rs1_rdata_o,
  output core_trace_pkg::xlen_t     rvfi_rs2_rdata_o,
  output core_trace_pkg::reg_addr_t rvfi_rd_addr_o,
  output core_trace_pkg::xlen_t     rvfi_rd_wdata_o,
  output core_trace_pkg::xlen_t     rvfi_pc_rdata_o,
  output core_trace_pkg::xlen_t     rvfi_mem_addr_o,
  output lsu_trace_pkg::mem_data_t  rvfi_mem_rdata_o,
  output lsu_trace_pkg::mem_data_t  rvfi_mem_wdata_o,
  output lsu_trace_pkg::mem_mask_t  rvfi_mem_rmask_o,
  output lsu_trace_pkg::mem_mask_t  rvfi_mem_wmask_o
);

  import core_trace_pkg::*;
  import lsu_trace_pkg::*;

  insn_t     insn_view;
  logic      trap;
  mem_mask_t wmask;

  // Compressed instructions show the zero-extended half
  assign insn_view = insn_compressed_i ? insn_t'(insn_c_rdata_i) : insn_rdata_i;

  assign trap  = load_err_i | store_err_i | cap_exc_i | illegal_insn_i;
  // Loads never write
  assign wmask = data_we_i ? mem_mask_i : '0;

  //////////////////////////////
  // Record register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o             <= 1'b0;
      rvfi_order_o             <= '0;
      rvfi_insn_o              <= '0;
      rvfi_insn_uncompressed_o <= '0;
      rvfi_trap_o              <= 1'b0;
      rvfi_intr_o              <= 1'b0;
      rvfi_rs1_addr_o          <= '0;
      rvfi_rs2_addr_o          <= '0;
      rvfi_rs1_rdata_o         <= '0;
      rvfi_rs2_rdata_o         <= '0;
      rvfi_rd_addr_o           <= '0;
      rvfi_rd_wdata_o          <= '0;
      rvfi_pc_rdata_o          <= '0;
      rvfi_mem_addr_o          <= '0;
      rvfi_mem_rdata_o         <= '0;
      rvfi_mem_wdata_o         <= '0;
      rvfi_mem_rmask_o         <= '0;
      rvfi_mem_wmask_o         <= '0;
    end else begin
      rvfi_valid_o             <= instr_ret_i;
      // Counts records already emitted
      rvfi_order_o             <= rvfi_order_o + OrderWidth'(rvfi_valid_o);
      rvfi_insn_o              <= insn_view;
      rvfi_insn_uncompressed_o <= insn_rdata_i;
      rvfi_trap_o              <= trap;
      rvfi_intr_o              <= irq_ack_i;
      rvfi_rs1_addr_o          <= rs1_addr_i;
      rvfi_rs2_addr_o          <= rs2_addr_i;
      rvfi_rs1_rdata_o         <= rs1_rdata_i;
      rvfi_rs2_rdata_o         <= rs2_rdata_i;
      rvfi_rd_addr_o           <= rd_addr_i;
      rvfi_rd_wdata_o          <= rd_wdata_i;
      rvfi_pc_rdata_o          <= pc_i;
      rvfi_mem_addr_o          <= mem_addr_i;
      rvfi_mem_rdata_o         <= mem_rdata_i;
      rvfi_mem_wdata_o         <= mem_wdata_i;
      rvfi_mem_rmask_o         <= mem_mask_i;
      rvfi_mem_wmask_o         <= wmask;
    end
  end

endmodule

// ==== hw/mem_capture.sv ====
// Memory capture for the retirement trace
// Holds LSU address and data of the open instruction, derives the byte mask

module mem_capture (
  input  logic                      clk,
  input  logic                      rst_ni,

  input  logic                      insn_open_i,
  input  logic                      lsu_data_valid_i,
  input  logic                      lsu_addr_incr_i,
  input  core_trace_pkg::xlen_t     data_addr_i,
  input  lsu_trace_pkg::mem_data_t  data_rdata_i,
  input  lsu_trace_pkg::mem_data_t  data_wdata_i,
  input  lsu_trace_pkg::data_type_t data_type_i,

  output core_trace_pkg::xlen_t     mem_addr_o,
  output lsu_trace_pkg::mem_data_t  mem_rdata_o,
  output lsu_trace_pkg::mem_data_t  mem_wdata_o,
  output lsu_trace_pkg::mem_mask_t  mem_mask_o
);

  import core_trace_pkg::*;
  import lsu_trace_pkg::*;

  logic      capture;
  xlen_t     mem_addr_q;
  mem_data_t mem_rdata_q;
  mem_data_t mem_wdata_q;

  // LSU pulses outside an instruction are ignored
  assign capture = insn_open_i & lsu_data_valid_i;

  // Second half of a split access keeps the first address
  assign mem_addr_o  = (capture && !lsu_addr_incr_i) ? data_addr_i : mem_addr_q;
  assign mem_rdata_o = capture ? data_rdata_i : mem_rdata_q;
  assign mem_wdata_o = capture ? data_wdata_i : mem_wdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_addr_q  <= '0;
      mem_rdata_q <= '0;
      mem_wdata_q <= '0;
    end else begin
      mem_addr_q  <= mem_addr_o;
      mem_rdata_q <= mem_rdata_o;
      mem_wdata_q <= mem_wdata_o;
    end
  end

  //////////////////////////////
  // Byte mask
  //////////////////////////////

  always_comb begin
    unique case (data_type_i)
      TypeWord: mem_mask_o = MaskWord;
      TypeHalf: mem_mask_o = MaskHalf;
      TypeByte: mem_mask_o = MaskByte;
      TypeCap:  mem_mask_o = MaskCap;
    endcase
  end

endmodule

// ==== hw/operand_capture.sv ====
// Operand capture for the retirement trace
// Holds source operands from decode, destination write of the open instruction,
// and the open-instruction flag

module operand_capture (
  input  logic                      clk,
  input  logic                      rst_ni,

  input  logic                      instr_new_i,
  input  logic                      instr_ret_i,

  // Register file view
  input  core_trace_pkg::reg_addr_t rs1_addr_i,
  input  core_trace_pkg::reg_addr_t rs2_addr_i,
  input  core_trace_pkg::xlen_t     rs1_rdata_i,
  input  core_trace_pkg::xlen_t     rs2_rdata_i,
  input  core_trace_pkg::reg_addr_t rd_addr_i,
  input  core_trace_pkg::xlen_t     rd_wdata_i,
  input  logic                      rd_we_i,

  output logic                      insn_open_o,
  output core_trace_pkg::reg_addr_t rs1_addr_o,
  output core_trace_pkg::reg_addr_t rs2_addr_o,
  output core_trace_pkg::reg_addr_t rd_addr_o,
  output core_trace_pkg::xlen_t     rs1_rdata_o,
  output core_trace_pkg::xlen_t     rs2_rdata_o,
  output core_trace_pkg::xlen_t     rd_wdata_o
);

  import core_trace_pkg::*;

  logic      open_q;
  reg_addr_t rs1_addr_q;
  reg_addr_t rs2_addr_q;
  xlen_t     rs1_rdata_q;
  xlen_t     rs2_rdata_q;
  reg_addr_t rd_addr_q;
  xlen_t     rd_wdata_q;

  // Open from the decode cycle until retire has passed
  assign insn_open_o = instr_new_i | open_q;

  //////////////////////////////
  // Source operands
  //////////////////////////////

  // Only valid in the decode cycle, so take them there
  assign rs1_addr_o  = instr_new_i ? rs1_addr_i  : rs1_addr_q;
  assign rs2_addr_o  = instr_new_i ? rs2_addr_i  : rs2_addr_q;
  assign rs1_rdata_o = instr_new_i ? rs1_rdata_i : rs1_rdata_q;
  assign rs2_rdata_o = instr_new_i ? rs2_rdata_i : rs2_rdata_q;

  //////////////////////////////
  // Destination
  //////////////////////////////

  always_comb begin
    rd_addr_o  = rd_addr_q;
    rd_wdata_o = rd_wdata_q;
    if (insn_open_o) begin
      if (!rd_we_i) begin
        rd_addr_o  = '0;
        rd_wdata_o = '0;
      end else begin
        rd_addr_o  = rd_addr_i;
        // x0 always reads as zero
        rd_wdata_o = (rd_addr_i == '0) ? '0 : rd_wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q      <= 1'b0;
      rs1_addr_q  <= '0;
      rs2_addr_q  <= '0;
      rs1_rdata_q <= '0;
      rs2_rdata_q <= '0;
      rd_addr_q   <= '0;
      rd_wdata_q  <= '0;
    end else begin
      open_q      <= insn_open_o & ~instr_ret_i;
      rs1_addr_q  <= rs1_addr_o;
      rs2_addr_q  <= rs2_addr_o;
      rs1_rdata_q <= rs1_rdata_o;
      rs2_rdata_q <= rs2_rdata_o;
      rd_addr_q   <= rd_addr_o;
      rd_wdata_q  <= rd_wdata_o;
    end
  end

endmodule

// ==== hw/lsu_trace_pkg.sv ====
// Load/store side definitions for the retirement trace
// Access type codes, memory data and byte mask types, mask constants

package lsu_trace_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Wide enough to carry a capability
  localparam int unsigned MemDataWidth = 64;
  localparam int unsigned MemMaskWidth = MemDataWidth / 8;

  typedef logic [1:0]              data_type_t;
  typedef logic [MemDataWidth-1:0] mem_data_t;
  typedef logic [MemMaskWidth-1:0] mem_mask_t;

  //////////////////////////////
  // Access type codes
  //////////////////////////////

  localparam data_type_t TypeWord = 2'd0;
  localparam data_type_t TypeHalf = 2'd1;
  localparam data_type_t TypeByte = 2'd2;
  localparam data_type_t TypeCap  = 2'd3;

  //////////////////////////////
  // Byte masks per access type
  //////////////////////////////

  localparam mem_mask_t MaskWord = 8'b0000_1111;
  localparam mem_mask_t MaskHalf = 8'b0000_0011;
  localparam mem_mask_t MaskByte = 8'b0000_0001;
  localparam mem_mask_t MaskCap  = 8'b1111_1111;

endpackage

// ==== hw/core_trace_pkg.sv ====
// Core-side widths for the retirement trace
// Register data, register index, instruction words and order counter

package core_trace_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned XlenWidth    = 32;
  localparam int unsigned RegAddrWidth = 5;
  localparam int unsigned InsnWidth    = 32;
  localparam int unsigned InsnCWidth   = 16;

  // Order counter width unless the top level overrides it
  localparam int unsigned OrderWidthDefault = 64;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Register data and PC
  typedef logic [XlenWidth-1:0]    xlen_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // Full and compressed instruction
  typedef logic [InsnWidth-1:0]  insn_t;
  typedef logic [InsnCWidth-1:0] insn_c_t;

endpackage
